//--- src/tile_pkg.sv
`default_nettype none

package tile_pkg;

    localparam int NUM_LAYERS = 3;
    localparam int LINE_W     = 512;
    localparam int LAST_X     = 447;     // last visible pixel

    localparam logic [3:0] TRANSPARENT = 4'hf;

    typedef logic [16:0] vram_addr_t;    // word address
    typedef logic [15:0] vram_data_t;
    typedef logic [19:0] rom_addr_t;     // word address
    typedef logic [31:0] rom_data_t;     // eight pixels across four plane bytes

    typedef struct packed {
        logic [1:0] group;
        logic [4:0] pal;
        logic [3:0] colour;
    } pix_t;

    // line buffer entry with the layer that last wrote it
    typedef struct packed {
        logic [1:0] owner;
        pix_t       pix;
    } line_entry_t;

    localparam pix_t CLEAR_PIX = '{group: 2'd0, pal: 5'd0, colour: TRANSPARENT};

    ////////////////////////////////////////
    // tile geometry and pixel unpacking
    ////////////////////////////////////////

    // 8x8, 16x16 and 32x32 tiles
    function automatic int tile_log2(input int layer);
        return 3 + layer;
    endfunction

    // leading pixel of a word, hflip reads from the low end
    function automatic logic [3:0] lead_colour(input rom_data_t w, input logic flip);
        return flip ? {w[24], w[16], w[8], w[0]} : {w[31], w[23], w[15], w[7]};
    endfunction

endpackage

`default_nettype wire

//--- src/tile_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// request/hold memory port
interface mem_port_if #(
    parameter type addr_t = logic [15:0],
    parameter type data_t = logic [15:0]
);
    logic  cs;      // held with addr until ok
    addr_t addr;
    data_t data;    // valid with ok
    logic  ok;      // single-cycle pulse

    modport requester (output cs, output addr, input data, input ok);
    modport responder (input cs, input addr, output data, output ok);
endinterface

// pixel stream under credit flow control
interface pix_if;
    logic           valid;
    logic [8:0]     x;
    tile_pkg::pix_t pix;
    logic           credit;     // one pulse per retired pixel

    modport sender   (output valid, output x, output pix, input credit);
    modport receiver (input valid, input x, input pix, output credit);
endinterface

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int  N      = 3,
    parameter type addr_t = logic [15:0],
    parameter type data_t = logic [15:0]
) (
    input  wire           clk,
    input  wire           rst,
    mem_port_if.responder req [N],
    mem_port_if.requester mem
);

    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]  cs_v;
    addr_t         addr_v [N];
    logic          busy;        // grant held until ok
    logic [IW-1:0] grant;
    logic [IW-1:0] ptr;         // round-robin start
    logic [IW-1:0] pick;
    logic          found;

    for (genvar i = 0; i < N; i++) begin : g_req
        assign cs_v[i]     = req[i].cs;
        assign addr_v[i]   = req[i].addr;
        assign req[i].data = mem.data;
        assign req[i].ok   = mem.ok && busy && (grant == IW'(i));    // granted port only
    end

    // first requester at or after ptr
    always_comb begin
        int idx;
        pick  = ptr;
        found = 1'b0;
        for (int k = N - 1; k >= 0; k--) begin
            idx = int'(ptr) + k;
            if (idx >= N)
                idx -= N;
            if (cs_v[idx]) begin
                pick  = IW'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            grant <= '0;
            ptr   <= '0;
        end else if (busy) begin
            if (mem.ok) begin
                busy <= 1'b0;
                ptr  <= (grant == IW'(N - 1)) ? '0 : grant + 1'b1;
            end
        end else if (found) begin
            busy  <= 1'b1;
            grant <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && found)
            mem.addr <= addr_v[pick];
    end

    assign mem.cs = busy;   // drops for a cycle between grants

endmodule

`default_nettype wire

//--- src/tile_layer_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tile_layer_engine #(
    parameter int LAYER   = 0,
    parameter int CREDITS = 4
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           start,
    input  wire [8:0]     vrender,
    input  wire [15:0]    hpos,
    input  wire [15:0]    vpos,
    input  wire [15:0]    vram_base,
    input  wire [3:0]     bank_offset,
    input  wire [3:0]     bank_mask,
    input  wire [3:0]     bank_limit,
    output logic          line_done,
    mem_port_if.requester vram,
    mem_port_if.requester rom,
    pix_if.sender         pix
);

    localparam int TL  = tile_pkg::tile_log2(LAYER);
    localparam int TS  = 1 << TL;
    localparam int NCH = TS / 8;                        // ROM words per tile row
    localparam int CHW = (NCH > 1) ? $clog2(NCH) : 1;
    localparam int CW  = $clog2(CREDITS + 1);

    typedef enum logic [2:0] {S_IDLE, S_CODE, S_ATTR, S_ROM, S_PIX} state_t;

    state_t               state;
    logic [10:0]          vn;         // scrolled row
    logic [10:0]          hn;         // column of the current tile
    logic signed [9:0]    xc;         // screen x of the next pixel
    logic [2:0]           pcnt;       // pixel within word
    logic [CHW-1:0]       chunk;      // word within tile row
    logic [CW-1:0]        credits;
    logic [15:0]          code;
    logic                 hflip;
    logic                 vflip;
    logic [1:0]           grp;
    logic [4:0]           pal;
    tile_pkg::rom_data_t  word;

    logic [11:0]          scan;
    tile_pkg::vram_addr_t tile_addr;
    logic [TL-1:0]        row;
    logic [CHW-1:0]       wsel;
    logic [23:0]          pre;
    tile_pkg::rom_addr_t  rom_calc;
    tile_pkg::pix_t       out_pix;
    logic                 unmapped;
    logic                 visible;
    logic                 send;
    logic                 step;

    wire vram_fire = vram.cs && vram.ok;
    wire rom_fire  = rom.cs && rom.ok;

    ////////////////////////////////////////
    // address generation
    ////////////////////////////////////////

    always_comb begin
        scan      = {vn[TL+5:8], hn[TL+5:TL], vn[7:TL]};
        tile_addr = {vram_base, 1'b0} + {4'd0, scan, 1'b0};  // code then attribute
        row       = vn[TL-1:0] ^ {TL{vflip}};
        wsel      = hflip ? CHW'(NCH - 1) - chunk : chunk;   // right half first
        pre       = (24'(code) << (2 * TL - 3)) | (24'(row) << (TL - 3));
        pre       = pre | (24'(wsel) & 24'(NCH - 1));
        rom_calc  = {(pre[19:16] & bank_mask) | bank_offset, pre[15:0]};
        unmapped  = code[15:12] > bank_limit;
        out_pix.group  = grp;
        out_pix.pal    = pal;
        out_pix.colour = unmapped ? tile_pkg::TRANSPARENT : tile_pkg::lead_colour(word, hflip);
    end

    assign visible = !xc[9];
    assign send    = (state == S_PIX) && visible && (credits != '0);
    assign step    = (state == S_PIX) && (!visible || credits != '0);  // skips cost no credit

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            vram.cs   <= 1'b0;
            rom.cs    <= 1'b0;
            pix.valid <= 1'b0;
            line_done <= 1'b0;
            credits   <= '0;
            vn        <= '0;
            hn        <= '0;
            xc        <= '0;
            pcnt      <= '0;
            chunk     <= '0;
        end else begin
            pix.valid <= send;
            credits   <= credits + CW'(pix.credit) - CW'(send);
            case (state)
                S_IDLE: begin
                    if (start) begin
                        vn        <= vpos[10:0] + 11'(vrender);
                        hn        <= hpos[10:0] & ~11'(TS - 1);
                        xc        <= -10'(hpos[TL-1:0]);     // fine scroll left of x 0
                        credits   <= CW'(CREDITS);
                        line_done <= 1'b0;
                        chunk     <= '0;
                        state     <= S_CODE;
                    end
                end
                S_CODE, S_ATTR: begin
                    if (!vram.cs) begin
                        vram.cs <= 1'b1;
                    end else if (vram.ok) begin
                        vram.cs <= 1'b0;
                        state   <= (state == S_CODE) ? S_ATTR : S_ROM;
                    end
                end
                S_ROM: begin
                    if (!rom.cs) begin
                        rom.cs <= 1'b1;
                    end else if (rom.ok) begin
                        rom.cs <= 1'b0;
                        pcnt   <= '0;
                        state  <= S_PIX;
                    end
                end
                S_PIX: begin
                    if (step) begin
                        xc   <= xc + 10'sd1;
                        pcnt <= pcnt + 3'd1;
                        if (send && xc == 10'(tile_pkg::LAST_X)) begin
                            line_done <= 1'b1;
                            state     <= S_IDLE;
                        end else if (pcnt == 3'd7) begin
                            if (chunk == CHW'(NCH - 1)) begin
                                chunk <= '0;
                                hn    <= hn + 11'(TS);
                                state <= S_CODE;
                            end else begin
                                chunk <= chunk + 1'b1;
                                state <= S_ROM;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // tile data and pixel path
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ((state == S_CODE || state == S_ATTR) && !vram.cs)
            vram.addr <= tile_addr | 17'(state == S_ATTR);
        if (vram_fire && state == S_CODE)
            code <= vram.data;
        if (vram_fire && state == S_ATTR) begin
            grp   <= vram.data[8:7];
            vflip <= vram.data[6];
            hflip <= vram.data[5];
            pal   <= vram.data[4:0];
        end
        if (state == S_ROM && !rom.cs)
            rom.addr <= rom_calc;
        if (rom_fire)
            word <= rom.data;
        else if (step)
            word <= hflip ? word >> 1 : word << 1;
        if (send) begin
            pix.x   <= xc[8:0];
            pix.pix <= out_pix;
        end
    end

endmodule

`default_nettype wire

//--- src/line_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module line_mixer #(
    parameter int N       = 3,
    parameter int CREDITS = 4
) (
    input  wire            clk,
    input  wire            rst,
    input  wire            start,
    input  wire [N-1:0]    eng_done,
    input  wire [8:0]      rd_addr,
    output logic           done,
    output tile_pkg::pix_t rd_data,
    pix_if.receiver        pix [N]
);

    localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int LW = (N > 1) ? $clog2(N) : 1;
    localparam int CNW = $clog2(CREDITS + 1);

    typedef struct packed {
        logic [8:0]     x;
        tile_pkg::pix_t pix;
    } slot_t;

    tile_pkg::line_entry_t line_buf [tile_pkg::LINE_W];
    slot_t                 slot_mem [N][CREDITS];
    logic [PW-1:0]         wr_ptr [N];
    logic [PW-1:0]         rd_ptr [N];
    logic [CNW-1:0]        cnt [N];
    logic [N-1:0]          in_valid;
    slot_t                 in_slot [N];
    logic [N-1:0]          has;

    logic [LW-1:0]         rr;          // round-robin start
    logic [LW-1:0]         sel;
    logic                  take;
    slot_t                 head;
    logic                  clearing;
    logic [8:0]            clr_addr;

    logic                  s1_valid;    // write stage
    logic [LW-1:0]         s1_layer;
    slot_t                 s1_slot;
    tile_pkg::line_entry_t s1_old;
    tile_pkg::line_entry_t merged;

    for (genvar i = 0; i < N; i++) begin : g_in
        assign in_valid[i]   = pix[i].valid;
        assign in_slot[i]    = '{x: pix[i].x, pix: pix[i].pix};
        assign has[i]        = cnt[i] != '0;
        assign pix[i].credit = s1_valid && (s1_layer == LW'(i));  // on the write cycle
    end

    // picker, held off while the line clears
    always_comb begin
        int idx;
        sel  = rr;
        take = 1'b0;
        for (int k = N - 1; k >= 0; k--) begin
            idx = int'(rr) + k;
            if (idx >= N)
                idx -= N;
            if (has[idx]) begin
                sel  = LW'(idx);
                take = !clearing;
            end
        end
        head = slot_mem[sel][rd_ptr[sel]];
    end

    // higher or equal layer wins, transparent never overwrites
    always_comb begin
        merged = s1_old;
        if (s1_slot.pix.colour != tile_pkg::TRANSPARENT && 2'(s1_layer) >= s1_old.owner)
            merged = '{owner: 2'(s1_layer), pix: s1_slot.pix};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                cnt[i]    <= '0;
            end
            rr       <= '0;
            clearing <= 1'b0;
            clr_addr <= '0;
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (in_valid[i])
                    wr_ptr[i] <= (wr_ptr[i] == PW'(CREDITS - 1)) ? '0 : wr_ptr[i] + 1'b1;
                if (take && sel == LW'(i))
                    rd_ptr[i] <= (rd_ptr[i] == PW'(CREDITS - 1)) ? '0 : rd_ptr[i] + 1'b1;
                cnt[i] <= cnt[i] + CNW'(in_valid[i]) - CNW'(take && sel == LW'(i));
            end
            s1_valid <= take;
            if (take)
                rr <= (sel == LW'(N - 1)) ? '0 : sel + 1'b1;
            if (start) begin
                clearing <= 1'b1;
                clr_addr <= '0;
            end else if (clearing) begin
                clr_addr <= clr_addr + 9'd1;
                if (clr_addr == 9'(tile_pkg::LINE_W - 1))
                    clearing <= 1'b0;
            end
            done <= !start && !clearing && (&eng_done) && !s1_valid
                    && (has == '0) && (in_valid == '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (in_valid[i])
                slot_mem[i][wr_ptr[i]] <= in_slot[i];
        end
        s1_layer <= sel;
        s1_slot  <= head;
        // same x written this edge is forwarded
        s1_old   <= (s1_valid && s1_slot.x == head.x) ? merged : line_buf[head.x];
        if (clearing)
            line_buf[clr_addr] <= '{owner: 2'd0, pix: tile_pkg::CLEAR_PIX};
        else if (s1_valid)
            line_buf[s1_slot.x] <= merged;
        rd_data <= line_buf[rd_addr].pix;
    end

endmodule

`default_nettype wire

//--- src/tilemap_top.sv
`timescale 1ns/1ps
`default_nettype none

module tilemap_top #(
    parameter int NUM_LAYERS = tile_pkg::NUM_LAYERS,
    parameter int CREDITS    = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire [8:0]                       vrender,
    input  wire [NUM_LAYERS-1:0][15:0]      hpos,
    input  wire [NUM_LAYERS-1:0][15:0]      vpos,
    input  wire [NUM_LAYERS-1:0][15:0]      vram_base,
    input  wire [NUM_LAYERS-1:0][3:0]       bank_offset,
    input  wire [NUM_LAYERS-1:0][3:0]       bank_mask,
    input  wire [NUM_LAYERS-1:0][3:0]       bank_limit,
    output logic                            vram_cs,
    output tile_pkg::vram_addr_t            vram_addr,
    input  wire tile_pkg::vram_data_t       vram_data,
    input  wire                             vram_ok,
    output logic                            rom_cs,
    output tile_pkg::rom_addr_t             rom_addr,
    input  wire tile_pkg::rom_data_t        rom_data,
    input  wire                             rom_ok,
    input  wire [8:0]                       rd_addr,
    output tile_pkg::pix_t                  rd_data,
    output logic                            done
);

    mem_port_if #(.addr_t(tile_pkg::vram_addr_t), .data_t(tile_pkg::vram_data_t))
        vram_req [NUM_LAYERS] ();
    mem_port_if #(.addr_t(tile_pkg::vram_addr_t), .data_t(tile_pkg::vram_data_t))
        vram_ext ();
    mem_port_if #(.addr_t(tile_pkg::rom_addr_t), .data_t(tile_pkg::rom_data_t))
        rom_req [NUM_LAYERS] ();
    mem_port_if #(.addr_t(tile_pkg::rom_addr_t), .data_t(tile_pkg::rom_data_t))
        rom_ext ();
    pix_if pix_bus [NUM_LAYERS] ();

    logic [NUM_LAYERS-1:0] eng_done;

    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        tile_layer_engine #(.LAYER(i), .CREDITS(CREDITS)) engine_i (
            .clk(clk), .rst(rst), .start(start), .vrender(vrender),
            .hpos(hpos[i]), .vpos(vpos[i]), .vram_base(vram_base[i]),
            .bank_offset(bank_offset[i]), .bank_mask(bank_mask[i]),
            .bank_limit(bank_limit[i]), .line_done(eng_done[i]),
            .vram(vram_req[i]), .rom(rom_req[i]), .pix(pix_bus[i])
        );
    end

    mem_arbiter #(.N(NUM_LAYERS), .addr_t(tile_pkg::vram_addr_t),
                  .data_t(tile_pkg::vram_data_t)) vram_arb_i (
        .clk(clk), .rst(rst), .req(vram_req), .mem(vram_ext)
    );

    mem_arbiter #(.N(NUM_LAYERS), .addr_t(tile_pkg::rom_addr_t),
                  .data_t(tile_pkg::rom_data_t)) rom_arb_i (
        .clk(clk), .rst(rst), .req(rom_req), .mem(rom_ext)
    );

    line_mixer #(.N(NUM_LAYERS), .CREDITS(CREDITS)) mixer_i (
        .clk(clk), .rst(rst), .start(start), .eng_done(eng_done),
        .rd_addr(rd_addr), .done(done), .rd_data(rd_data), .pix(pix_bus)
    );

    // external memory ports
    assign vram_cs       = vram_ext.cs;
    assign vram_addr     = vram_ext.addr;
    assign vram_ext.data = vram_data;
    assign vram_ext.ok   = vram_ok;
    assign rom_cs        = rom_ext.cs;
    assign rom_addr      = rom_ext.addr;
    assign rom_ext.data  = rom_data;
    assign rom_ext.ok    = rom_ok;

endmodule

`default_nettype wire

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// word memory that answers a held cs with a one-cycle ok after a random wait
module tb_mem_model #(
    parameter int AW = 17,
    parameter int DW = 16
) (
    input  wire           clk,
    input  wire           rst,
    input  wire [4:0]     max_delay,    // ok comes 1 to max_delay cycles after cs
    input  wire           cs,
    input  wire [AW-1:0]  addr,
    output logic [DW-1:0] data,
    output logic          ok
);

    logic [DW-1:0] mem [1 << AW];
    logic          active;     // access accepted, counting down
    int            wait_cnt;

    // random contents, one draw per word
    task automatic fill();
        for (int a = 0; a < (1 << AW); a++)
            mem[a] = DW'($urandom);
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            wait_cnt <= 0;
            ok       <= 1'b0;
            data     <= '0;
        end else begin
            ok <= 1'b0;
            if (active) begin
                if (wait_cnt == 0) begin
                    active <= 1'b0;
                    ok     <= 1'b1;
                    data   <= mem[addr];
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (cs && !ok) begin    // cs still high on the cycle after ok
                active   <= 1'b1;
                wait_cnt <= int'($urandom % 32'(max_delay));
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_tilemap.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tilemap;

    localparam int          NL            = tile_pkg::NUM_LAYERS;
    localparam int          CLK_PERIOD    = 4;
    localparam int          NUM_SCEN      = 10;         // lines rendered
    localparam int          SCEN_CYCLES   = 20000;
    localparam int          LINE_LIMIT    = 20000;      // cycles from start to done
    localparam int          LAST_X        = 447;
    localparam logic [31:0] SEED          = 32'h7558ba24;
    localparam logic [15:0] UNMAPPED_BASE = 16'h4000;   // every code above limit 0
    localparam logic [15:0] FLIP_BASE     = 16'h5000;   // every tile flipped both ways

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic [8:0]           vrender;
    logic [NL-1:0][15:0]  hpos;
    logic [NL-1:0][15:0]  vpos;
    logic [NL-1:0][15:0]  vram_base;
    logic [NL-1:0][3:0]   bank_offset;
    logic [NL-1:0][3:0]   bank_mask;
    logic [NL-1:0][3:0]   bank_limit;
    logic                 vram_cs;
    tile_pkg::vram_addr_t vram_addr;
    tile_pkg::vram_data_t vram_data;
    logic                 vram_ok;
    logic                 rom_cs;
    tile_pkg::rom_addr_t  rom_addr;
    tile_pkg::rom_data_t  rom_data;
    logic                 rom_ok;
    logic [8:0]           rd_addr;
    tile_pkg::pix_t       rd_data;
    logic                 done;
    logic [4:0]           max_delay;

    tilemap_top #(.NUM_LAYERS(NL), .CREDITS(4)) dut_i (
        .clk(clk), .rst(rst), .start(start), .vrender(vrender),
        .hpos(hpos), .vpos(vpos), .vram_base(vram_base), .bank_offset(bank_offset),
        .bank_mask(bank_mask), .bank_limit(bank_limit),
        .vram_cs(vram_cs), .vram_addr(vram_addr), .vram_data(vram_data), .vram_ok(vram_ok),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .rd_addr(rd_addr), .rd_data(rd_data), .done(done)
    );

    tb_mem_model #(.AW(17), .DW(16)) vram_i (
        .clk(clk), .rst(rst), .max_delay(max_delay),
        .cs(vram_cs), .addr(vram_addr), .data(vram_data), .ok(vram_ok)
    );

    tb_mem_model #(.AW(20), .DW(32)) rom_i (
        .clk(clk), .rst(rst), .max_delay(max_delay),
        .cs(rom_cs), .addr(rom_addr), .data(rom_data), .ok(rom_ok)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // reference line model
    ////////////////////////////////////////

    // pixel of one layer at screen x from the model contents
    function automatic tile_pkg::pix_t layer_pixel(input int layer, input int x);
        int             tl;
        int             ts;
        int             h;
        int             v;
        int             col;
        int             r;
        int             scan;
        int             pre;
        logic [16:0]    a;
        logic [15:0]    code;
        logic [15:0]    attr;
        logic [19:0]    ra;
        logic [31:0]    w;
        tile_pkg::pix_t p;
        tl   = 3 + layer;                                   // 8, 16, 32 pixel tiles
        ts   = 1 << tl;
        h    = (int'(hpos[layer][10:0]) + x) % 2048;
        v    = (int'(vpos[layer][10:0]) + int'(vrender)) % 2048;
        scan = (((v >> 8) % (1 << (tl - 2))) << (14 - tl))
             + (((h >> tl) % 64) << (8 - tl)) + ((v % 256) >> tl);
        a    = 17'(2 * int'(vram_base[layer]) + 2 * scan);  // code word then attribute word
        code = vram_i.mem[a];
        attr = vram_i.mem[a + 17'd1];
        col  = attr[5] ? ts - 1 - h % ts : h % ts;
        r    = attr[6] ? ts - 1 - v % ts : v % ts;
        pre  = int'(code) * (ts * ts / 8) + r * (ts / 8) + col / 8;
        ra   = 20'(pre);
        ra[19:16] = (ra[19:16] & bank_mask[layer]) | bank_offset[layer];
        w    = rom_i.mem[ra];
        p.group = attr[8:7];
        p.pal   = attr[4:0];
        for (int b = 0; b < 4; b++)
            p.colour[b] = w[8 * b + 7 - col % 8];           // one bit per plane byte
        if (code[15:12] > bank_limit[layer])
            p.colour = 4'hf;
        return p;
    endfunction

    // highest opaque layer or the cleared entry
    function automatic tile_pkg::pix_t expected_pixel(input int x);
        tile_pkg::pix_t e;
        tile_pkg::pix_t p;
        e = '{group: 2'd0, pal: 5'd0, colour: 4'hf};
        for (int l = 0; l < NL; l++) begin
            p = layer_pixel(l, x);
            if (p.colour != 4'hf)
                e = p;
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // force code and attribute bits in two tilemap regions
    task automatic shape_vram();
        for (int a = 2 * int'(UNMAPPED_BASE); a < 2 * int'(UNMAPPED_BASE) + 8192; a += 2)
            vram_i.mem[17'(a)] = vram_i.mem[17'(a)] | 16'h1000;
        for (int a = 2 * int'(FLIP_BASE); a < 2 * int'(FLIP_BASE) + 8192; a += 2)
            vram_i.mem[17'(a + 1)] = vram_i.mem[17'(a + 1)] | 16'h0060;
    endtask

    task set_layer(input int layer, input logic [15:0] h, input logic [15:0] v,
                   input logic [15:0] base, input logic [3:0] offset,
                   input logic [3:0] mask, input logic [3:0] limit);
        hpos[layer]        <= h;
        vpos[layer]        <= v;
        vram_base[layer]   <= base;
        bank_offset[layer] <= offset;
        bank_mask[layer]   <= mask;
        bank_limit[layer]  <= limit;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        assert (!done) else begin
            $display("done stayed high after start");
            abort_run();
        end
        while (!done) begin
            n++;
            if (n > LINE_LIMIT) begin
                $display("done did not rise within %0d cycles", LINE_LIMIT);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task check_line();
        tile_pkg::pix_t exp;
        for (int a = 0; a <= LAST_X; a++) begin
            @(posedge clk);
            rd_addr <= 9'(a);
            @(posedge clk);
            @(negedge clk);                 // rd_data one cycle after rd_addr
            exp = expected_pixel(a);
            assert (done) else begin
                $display("done dropped while the line was read back");
                abort_run();
            end
            assert (rd_data == exp) else begin
                $display("FAIL rd_data at x 0x%03h: got 0x%03h, expected 0x%03h",
                         9'(a), rd_data, exp);
                abort_run();
            end
        end
    endtask

    task run_line(input logic [8:0] line);
        @(posedge clk);
        vrender <= line;
        start   <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        wait_done();
        check_line();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        vrender     = '0;
        hpos        = '0;
        vpos        = '0;
        vram_base   = '0;
        bank_offset = '0;
        bank_mask   = '1;
        bank_limit  = '1;
        rd_addr     = '0;
        max_delay   = 5'd6;
        void'($urandom(SEED));
        vram_i.fill();
        rom_i.fill();
        shape_vram();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // memory selects and done idle out of reset
        @(negedge clk);
        assert (!vram_cs && !rom_cs && !done) else begin
            $display("memory select or done high after reset");
            abort_run();
        end

        // layer 0 alone without scroll
        @(posedge clk);
        set_layer(0, 16'h0000, 16'h0000, 16'h0000, 4'h0, 4'hf, 4'hf);
        set_layer(1, 16'h0000, 16'h0000, UNMAPPED_BASE, 4'h0, 4'hf, 4'h0);
        set_layer(2, 16'h0000, 16'h0000, UNMAPPED_BASE, 4'h0, 4'hf, 4'h0);
        run_line(9'd37);

        // each layer alone with coarse and fine scroll
        @(posedge clk);
        set_layer(0, 16'h0123, 16'h0045, 16'h0000, 4'h0, 4'hf, 4'hf);
        run_line(9'd100);
        @(posedge clk);
        set_layer(0, 16'h0000, 16'h0000, UNMAPPED_BASE, 4'h0, 4'hf, 4'h0);
        set_layer(1, 16'h02b7, 16'h0339, 16'h1000, 4'h0, 4'hf, 4'hf);
        run_line(9'd211);
        @(posedge clk);
        set_layer(1, 16'h0000, 16'h0000, UNMAPPED_BASE, 4'h0, 4'hf, 4'h0);
        set_layer(2, 16'h07ed, 16'h01f3, 16'h2000, 4'h0, 4'hf, 4'hf);   // wraps past 2047
        run_line(9'd5);

        // flipped tiles on every layer
        @(posedge clk);
        set_layer(0, 16'h0035, 16'h0013, FLIP_BASE, 4'h0, 4'hf, 4'hf);
        set_layer(1, 16'h0109, 16'h0027, FLIP_BASE, 4'h0, 4'hf, 4'hf);
        set_layer(2, 16'h0061, 16'h0155, FLIP_BASE, 4'h0, 4'hf, 4'hf);
        run_line(9'd77);

        // bank limit, mask and offset
        @(posedge clk);
        set_layer(0, 16'h0010, 16'h0008, 16'h0000, 4'h4, 4'h3, 4'h7);
        set_layer(1, 16'h0021, 16'h0100, 16'h1000, 4'h8, 4'h5, 4'h9);
        set_layer(2, 16'h0003, 16'h0022, 16'h2000, 4'h2, 4'hc, 4'hb);
        run_line(9'd150);

        // all layers with random scroll
        @(posedge clk);
        set_layer(0, 16'($urandom), 16'($urandom), 16'h0000, 4'h0, 4'hf, 4'hf);
        set_layer(1, 16'($urandom), 16'($urandom), 16'h1000, 4'h0, 4'hf, 4'hf);
        set_layer(2, 16'($urandom), 16'($urandom), 16'h2000, 4'h0, 4'hf, 4'hf);
        run_line(9'd260);

        // slow memories and back-to-back lines
        @(posedge clk);
        max_delay <= 5'd16;
        run_line(9'd300);
        run_line(9'd301);
        run_line(9'd511);

        $display("RESULT: PASS");
        $finish;
    end

    // watchdog over all scenarios
    initial begin
        #(SCEN_CYCLES * NUM_SCEN * CLK_PERIOD);
        $display("watchdog expired before the scenarios finished");
        abort_run();
    end

endmodule

`default_nettype wire

//--- sim.f
src/tile_pkg.sv
src/tile_ifs.sv
src/mem_arbiter.sv
src/tile_layer_engine.sv
src/line_mixer.sv
src/tilemap_top.sv
tests/tb_mem_model.sv
tests/tb_tilemap.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench, then search its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_tilemap -f sim.f -o tb_tilemap \
    && ./obj_dir/tb_tilemap > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -qs "RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
